// ==== source/sm83_macros.svh ====
`ifndef SM83_MACROS_SVH
`define SM83_MACROS_SVH

// width of both the internal DL bus and the external D bus
`define DATA_WIDTH 8

// DL floats high when nobody pulls it down
`define PRECHARGE_VALUE {`DATA_WIDTH{1'b1}}

// D bus value after reset, before the first write cycle
`define EXT_RESET_VALUE {`DATA_WIDTH{1'b0}}

`endif

// ==== source/busCyclePkg.sv ====
`default_nettype none

`include "sm83_macros.svh"

// what the core does on the external data bus in one cycle
package busCyclePkg;

	// encoded as {rd, wr} so the decode stays trivial
	typedef enum logic [1:0] {
		cycleIdle     = 2'b00, // no access
		cycleRead     = 2'b10, // D -> DL
		cycleWrite    = 2'b01, // DL -> D
		cycleConflict = 2'b11  // rd and wr together, nothing gets driven
	} cycleKindT;

	// what the bridge puts on the D pins
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] data; // byte on D
		logic                   oe;   // pins actively driven
	} extDriveT;

endpackage

`default_nettype wire

// ==== source/dataPathPkg.sv ====
`default_nettype none

`include "sm83_macros.svh"

// everything that can pull the internal DL bus low
package dataPathPkg;

	// one enable per open-drain source on DL
	typedef struct packed {
		logic aluEn; // ALU result onto DL (resToDl)
		logic extEn; // latched D byte onto DL on an internal read
		logic dvEn;  // DV operand onto DL during a write
	} dlSourcesT;

	// values the sources hold while DL resolves
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] res; // ALU result
		logic [`DATA_WIDTH-1:0] ext; // last byte read from D
		logic [`DATA_WIDTH-1:0] dv;  // ALU operand 2
	} dlOperandsT;

	// the source count, handy when checking the enable record
	localparam int unsigned DL_SOURCE_COUNT = $bits(dlSourcesT);

endpackage

`default_nettype wire

// ==== source/dlBusIf.sv ====
`default_nettype none

`include "sm83_macros.svh"

// one bus cycle in flight between two pipeline stages
interface dlBusIf;

	busCyclePkg::cycleKindT  kind;       // rd/wr classification
	logic                    busDisable; // Test1, keeps the core off D
	dataPathPkg::dlSourcesT  sources;    // which sources pull DL
	dataPathPkg::dlOperandsT operands;   // their values
	logic [`DATA_WIDTH-1:0]  dl;         // resolved DL byte
	logic                    dlDriven;   // at least one source was on

	// sampler -> resolver, before DL is known
	modport sampledProducer (output kind, output busDisable, output sources, output operands);
	modport sampledConsumer (input kind, input busDisable, input sources, input operands);

	// resolver -> driver, DL already settled
	modport resolvedProducer (output kind, output busDisable, output dl, output dlDriven);
	modport resolvedConsumer (input kind, input busDisable, input dl, input dlDriven);

endinterface

`default_nettype wire

// ==== source/busKeeper.sv ====
`default_nettype none

// holds whatever was last put on it, like the keeper cells on the real buses
module busKeeper #(
	parameter type payloadT = logic [7:0] // byte by default
) (
	input  wire          CLK,
	input  wire          rstN,
	input  wire          load, // take d on this edge
	input  wire payloadT d,
	output payloadT      q
);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			q <= '0; // keepers start out empty
		end else if (load) begin
			q <= d;
		end
		// no load, old value stays
	end

endmodule

`default_nettype wire

// ==== source/busSampler.sv ====
`default_nettype none

`include "sm83_macros.svh"

// stage 1: look at rd/wr and the decoder levels, decide who may pull DL
module busSampler (
	input  wire                   CLK,
	input  wire                   rstN,
	input  wire                   rd,         // external read strobe
	input  wire                   wr,         // external write strobe
	input  wire                   ieSelect,   // IE register access, D is not read
	input  wire                   busDisable, // Test1
	input  wire                   resToDl,    // ALU result -> DL
	input  wire [`DATA_WIDTH-1:0] res,        // ALU result, always valid
	input  wire                   dataOut,    // DV -> DL on writes
	input  wire [`DATA_WIDTH-1:0] dv,         // ALU operand 2
	input  wire [`DATA_WIDTH-1:0] extIn,      // D pins as seen from the core
	dlBusIf.sampledProducer       sampled
);

	busCyclePkg::cycleKindT kindNext;
	dataPathPkg::dlSourcesT sourcesNext;
	logic                   intRead;  // read that really reaches DL
	logic                   extLoad;
	logic [`DATA_WIDTH-1:0] extKept;  // D byte from the last read
	logic [`DATA_WIDTH-1:0] resQ;
	logic [`DATA_WIDTH-1:0] dvQ;

	always_comb begin
		case ({rd, wr})
			2'b10:   kindNext = busCyclePkg::cycleRead;
			2'b01:   kindNext = busCyclePkg::cycleWrite;
			2'b11:   kindNext = busCyclePkg::cycleConflict; // both strobes, treat as no access
			default: kindNext = busCyclePkg::cycleIdle;
		endcase
	end

	// IE reads come from inside, and Test1 cuts D off entirely
	assign intRead = (kindNext == busCyclePkg::cycleRead) && !ieSelect && !busDisable;

	assign sourcesNext.aluEn = resToDl;
	assign sourcesNext.extEn = intRead;
	assign sourcesNext.dvEn  = (kindNext == busCyclePkg::cycleWrite) && dataOut;

	// D is captured on every read, even an IE one, same as the pin latch
	assign extLoad = (kindNext == busCyclePkg::cycleRead);

	busKeeper #(
		.payloadT(logic [`DATA_WIDTH-1:0])
	) extKeeper (
		.CLK (CLK),
		.rstN(rstN),
		.load(extLoad),
		.d   (extIn),
		.q   (extKept) // already one edge late, lines up with the flops below
	);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			sampled.kind       <= busCyclePkg::cycleIdle;
			sampled.busDisable <= 1'b0;
			sampled.sources    <= '0; // nobody on DL after reset
		end else begin
			sampled.kind       <= kindNext;
			sampled.busDisable <= busDisable;
			sampled.sources    <= sourcesNext;
		end
	end

	// operand bytes only matter when their enable is set
	always_ff @(posedge CLK) begin
		resQ <= res;
		dvQ  <= dv;
	end

	assign sampled.operands = '{res: resQ, ext: extKept, dv: dvQ};

endmodule

`default_nettype wire

// ==== source/dlResolver.sv ====
`default_nettype none

`include "sm83_macros.svh"

// stage 2: DL is precharged high and every enabled source pulls its zeros low
module dlResolver (
	input  wire              CLK,
	input  wire              rstN,
	dlBusIf.sampledConsumer  sampled,
	dlBusIf.resolvedProducer resolved
);

	logic [`DATA_WIDTH-1:0] dlNext;
	logic                   drivenNext;
	logic [`DATA_WIDTH-1:0] aluPull;  // ones where the ALU leaves DL alone
	logic [`DATA_WIDTH-1:0] extPull;
	logic [`DATA_WIDTH-1:0] dvPull;

	// a disabled source looks like all ones, so it drops out of the AND
	assign aluPull = sampled.sources.aluEn ? sampled.operands.res : `PRECHARGE_VALUE;
	assign extPull = sampled.sources.extEn ? sampled.operands.ext : `PRECHARGE_VALUE;
	assign dvPull  = sampled.sources.dvEn  ? sampled.operands.dv  : `PRECHARGE_VALUE;

	always_comb begin
		dlNext = `PRECHARGE_VALUE;   // precharge phase
		dlNext = dlNext & aluPull;   // open-drain pull-downs, any zero wins
		dlNext = dlNext & extPull;
		dlNext = dlNext & dvPull;
		drivenNext = |sampled.sources;
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			resolved.dl       <= `PRECHARGE_VALUE;
			resolved.dlDriven <= 1'b0;
			resolved.kind     <= busCyclePkg::cycleIdle;
			resolved.busDisable <= 1'b0;
		end else begin
			resolved.dl       <= dlNext;
			resolved.dlDriven <= drivenNext;
			// carried along so stage 3 acts on the cycle this DL belongs to
			resolved.kind       <= sampled.kind;
			resolved.busDisable <= sampled.busDisable;
		end
	end

endmodule

`default_nettype wire

// ==== source/busDriver.sv ====
`default_nettype none

`include "sm83_macros.svh"

// stage 3: put DL onto D for a write, otherwise release the pins
module busDriver (
	input  wire                    CLK,
	input  wire                    rstN,
	dlBusIf.resolvedConsumer       resolved,
	output logic [`DATA_WIDTH-1:0] extOut, // D byte
	output logic                   extOe   // D pins enabled
);

	logic                  writeNow;  // write that is allowed onto D
	busCyclePkg::extDriveT driveNext;
	busCyclePkg::extDriveT driveKept; // last write, survives idle cycles
	logic                  oeQ;

	// Test1 keeps the core off the pins even during a write
	assign writeNow = (resolved.kind == busCyclePkg::cycleWrite) && !resolved.busDisable;

	assign driveNext = '{data: resolved.dl, oe: 1'b1};

	busKeeper #(
		.payloadT(busCyclePkg::extDriveT)
	) driveKeeper (
		.CLK (CLK),
		.rstN(rstN),
		.load(writeNow),
		.d   (driveNext),
		.q   (driveKept)
	);

	// the keeper never forgets its enable, this flop drops it after the write
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			oeQ <= 1'b0;
		end else begin
			oeQ <= writeNow;
		end
	end

	assign extOut = driveKept.data;         // held byte, like the D bus keeper
	assign extOe  = oeQ & driveKept.oe;     // only in the cycle after a write

endmodule

`default_nettype wire

// ==== source/dataMux.sv ====
`default_nettype none

`include "sm83_macros.svh"

// SM83 data bus bridge between internal DL and external D
// three stages: sample, resolve, drive
module dataMux (
	input  wire                    CLK,
	input  wire                    rstN,
	input  wire                    busDisable, // Test1 pin
	input  wire                    resToDl,    // decoder, ALU result -> DL
	input  wire [`DATA_WIDTH-1:0]  res,        // ALU result
	input  wire                    dataOut,    // decoder, DV -> DL
	input  wire [`DATA_WIDTH-1:0]  dv,         // ALU operand 2
	input  wire                    rd,
	input  wire                    wr,
	input  wire                    ieSelect,   // access hits the IE register
	input  wire [`DATA_WIDTH-1:0]  extIn,      // D pins, input side
	output logic [`DATA_WIDTH-1:0] extOut,     // D pins, output side
	output logic                   extOe,      // D pins, enable
	output logic [`DATA_WIDTH-1:0] dl,         // internal bus, two edges after inputs
	output logic                   dlDriven    // some source pulled DL
);

	dlBusIf sampled ();  // stage 1 -> stage 2
	dlBusIf resolved (); // stage 2 -> stage 3

	busSampler sampler (
		.CLK       (CLK),
		.rstN      (rstN),
		.rd        (rd),
		.wr        (wr),
		.ieSelect  (ieSelect),
		.busDisable(busDisable),
		.resToDl   (resToDl),
		.res       (res),
		.dataOut   (dataOut),
		.dv        (dv),
		.extIn     (extIn),
		.sampled   (sampled.sampledProducer)
	);

	dlResolver resolver (
		.CLK     (CLK),
		.rstN    (rstN),
		.sampled (sampled.sampledConsumer),
		.resolved(resolved.resolvedProducer)
	);

	busDriver driver (
		.CLK     (CLK),
		.rstN    (rstN),
		.resolved(resolved.resolvedConsumer),
		.extOut  (extOut),
		.extOe   (extOe)
	);

	// DL itself is visible outside, mainly for the rest of the core
	assign dl       = resolved.dl;
	assign dlDriven = resolved.dlDriven;

endmodule

`default_nettype wire

// ==== verification/dataMuxTb.sv ====
`default_nettype none

`include "sm83_macros.svh"

// directed tests for the DL/D bridge checked every cycle against a rule model
module dataMuxTb;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	localparam int RAND_COUNT   = 16;  // iterations in the ALU, read and write tests
	localparam int HOLD_CYCLES  = 12;  // upper bound for the hold/conflict test
	localparam int MIX_COUNT    = 200; // random back-to-back cycles
	localparam int FLUSH_CYCLES = 3;   // drain the pipeline at the end
	// one cycle per ALU iteration and four per read or write iteration
	localparam int TEST_CYCLES  = RESET_CYCLES + 9 * RAND_COUNT + HOLD_CYCLES
		+ MIX_COUNT + FLUSH_CYCLES;
	localparam int TIMEOUT_TIME = (TEST_CYCLES + 50) * CLK_PERIOD;

	// one bus cycle worth of DUT inputs
	typedef struct packed {
		logic                   rd;
		logic                   wr;
		logic                   ieSelect;
		logic                   busDisable;
		logic                   resToDl;
		logic [`DATA_WIDTH-1:0] res;
		logic                   dataOut;
		logic [`DATA_WIDTH-1:0] dv;
		logic [`DATA_WIDTH-1:0] extIn;
	} stimT;

	logic                   CLK;
	logic                   rstN;
	logic                   busDisable;
	logic                   resToDl;
	logic [`DATA_WIDTH-1:0] res;
	logic                   dataOut;
	logic [`DATA_WIDTH-1:0] dv;
	logic                   rd;
	logic                   wr;
	logic                   ieSelect;
	logic [`DATA_WIDTH-1:0] extIn;
	logic [`DATA_WIDTH-1:0] extOut;
	logic                   extOe;
	logic [`DATA_WIDTH-1:0] dl;
	logic                   dlDriven;

	logic [`DATA_WIDTH:0]   dlQueue[$];  // {dlDriven, dl} still in flight
	logic [`DATA_WIDTH:0]   extQueue[$]; // {extOe, extOut} still in flight
	logic [`DATA_WIDTH-1:0] heldOut;     // model of the D keeper

	dataMux UUT (
		.CLK       (CLK),
		.rstN      (rstN),
		.busDisable(busDisable),
		.resToDl   (resToDl),
		.res       (res),
		.dataOut   (dataOut),
		.dv        (dv),
		.rd        (rd),
		.wr        (wr),
		.ieSelect  (ieSelect),
		.extIn     (extIn),
		.extOut    (extOut),
		.extOe     (extOe),
		.dl        (dl),
		.dlDriven  (dlDriven)
	);

	initial CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// ends a run that got stuck somewhere
	initial begin
		#(TIMEOUT_TIME);
		$display("timeout: the tests did not finish within %0d time units", TIMEOUT_TIME);
		$display("FAIL: see errors above");
		$fatal(1);
	end

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	function automatic logic [`DATA_WIDTH-1:0] randomByte();
		return $urandom % 256;
	endfunction

	// all controls off with junk on the data lines that must not leak onto DL
	function automatic stimT idleStim();
		stimT s;
		s = '0;
		s.res   = randomByte();
		s.dv    = randomByte();
		s.extIn = randomByte();
		return s;
	endfunction

	// DL starts precharged and each enabled source clears its zero bits
	function automatic logic [`DATA_WIDTH:0] predictDl(input stimT s);
		logic [`DATA_WIDTH-1:0] value;
		logic                   anyOn;
		value = `PRECHARGE_VALUE;
		anyOn = 1'b0;
		if (s.resToDl) begin
			value = value & s.res;
			anyOn = 1'b1;
		end
		if (s.rd && !s.wr && !s.ieSelect && !s.busDisable) begin // internal read
			value = value & s.extIn;
			anyOn = 1'b1;
		end
		if (s.wr && !s.rd && s.dataOut) begin // DV during a write
			value = value & s.dv;
			anyOn = 1'b1;
		end
		return {anyOn, value};
	endfunction

	// drives one cycle and queues its results before checking what comes out now
	task automatic applyCycle(input stimT s);
		logic [`DATA_WIDTH:0] expected;
		logic [`DATA_WIDTH:0] expDl;
		logic [`DATA_WIDTH:0] expExt;
		@(posedge CLK);
		rd         <= s.rd;
		wr         <= s.wr;
		ieSelect   <= s.ieSelect;
		busDisable <= s.busDisable;
		resToDl    <= s.resToDl;
		res        <= s.res;
		dataOut    <= s.dataOut;
		dv         <= s.dv;
		extIn      <= s.extIn;
		expected = predictDl(s);
		dlQueue.push_back(expected);
		if (s.wr && !s.rd && !s.busDisable) begin
			heldOut = expected[`DATA_WIDTH-1:0]; // D takes DL
			extQueue.push_back({1'b1, heldOut});
		end else begin
			extQueue.push_back({1'b0, heldOut}); // pins released but the byte is kept
		end
		@(negedge CLK); // outputs settled here
		expDl  = dlQueue.pop_front();
		expExt = extQueue.pop_front();
		checkValue(dl, expDl[`DATA_WIDTH-1:0], "dl");
		checkValue(dlDriven, expDl[`DATA_WIDTH], "dlDriven");
		checkValue(extOut, expExt[`DATA_WIDTH-1:0], "extOut");
		checkValue(extOe, expExt[`DATA_WIDTH], "extOe");
	endtask

	task automatic resetDut();
		rstN <= 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		rstN <= 1'b1;
		heldOut = '0;
		// reset values fill the two DL slots and three D slots before the first result
		repeat (2) dlQueue.push_back({1'b0, `PRECHARGE_VALUE});
		repeat (3) extQueue.push_back({1'b0, {`DATA_WIDTH{1'b0}}});
	endtask

	task automatic afterReset();
		@(negedge CLK);
		checkValue(extOe, 1'b0, "extOe after reset");
		checkValue(extOut, '0, "extOut after reset");
		checkValue(dl, `PRECHARGE_VALUE, "dl after reset");
		checkValue(dlDriven, 1'b0, "dlDriven after reset");
	endtask

	task automatic aluOntoDl();
		stimT s;
		repeat (RAND_COUNT) begin
			s = idleStim();
			s.resToDl = 1'b1; // only the ALU on DL
			applyCycle(s);
		end
	endtask

	task automatic readsOntoDl();
		stimT s;
		repeat (RAND_COUNT) begin
			s = idleStim();
			s.rd = 1'b1;
			applyCycle(s); // plain read
			s = idleStim();
			s.rd       = 1'b1;
			s.ieSelect = 1'b1;
			applyCycle(s); // IE access leaves DL precharged
			s = idleStim();
			s.rd         = 1'b1;
			s.busDisable = 1'b1;
			applyCycle(s);
			s = idleStim();
			s.rd      = 1'b1;
			s.resToDl = 1'b1; // both pull so DL is the AND of the two
			applyCycle(s);
		end
	endtask

	task automatic writesOntoD();
		stimT s;
		repeat (RAND_COUNT) begin
			s = idleStim();
			s.wr      = 1'b1;
			s.dataOut = 1'b1;
			applyCycle(s);
			s = idleStim();
			s.wr         = 1'b1;
			s.dataOut    = 1'b1;
			s.busDisable = 1'b1; // Test1 keeps the pins off
			applyCycle(s);
			s = idleStim();
			s.wr      = 1'b1;
			s.dataOut = 1'b1;
			s.resToDl = 1'b1;
			applyCycle(s);
			s = idleStim();
			s.wr = 1'b1; // write with nothing on DL puts out the precharge
			applyCycle(s);
		end
	endtask

	task automatic holdAndConflict();
		stimT                   s;
		logic [`DATA_WIDTH-1:0] lastByte;
		s = idleStim();
		s.wr      = 1'b1;
		s.dataOut = 1'b1;
		lastByte  = s.dv;
		applyCycle(s);
		repeat (4) applyCycle(idleStim());
		checkValue(extOut, lastByte, "extOut held after write");
		checkValue(extOe, 1'b0, "extOe released after write");
		repeat (2) begin
			s = idleStim();
			s.rd      = 1'b1;
			s.wr      = 1'b1; // conflict drives nothing
			s.dataOut = 1'b1;
			applyCycle(s);
		end
		repeat (4) applyCycle(idleStim());
		checkValue(extOut, lastByte, "extOut held after conflict");
	endtask

	task automatic mixedBackToBack();
		stimT s;
		repeat (MIX_COUNT) begin
			s.rd         = $urandom % 2;
			s.wr         = $urandom % 2;
			s.ieSelect   = $urandom % 2;
			s.busDisable = ($urandom % 4) == 0; // rarer so most writes stay visible
			s.resToDl    = $urandom % 2;
			s.res        = randomByte();
			s.dataOut    = $urandom % 2;
			s.dv         = randomByte();
			s.extIn      = randomByte();
			applyCycle(s);
		end
	endtask

	initial begin
		void'($urandom(32'hb901_9c22)); // one seed for the whole run
		rstN       = 1'b0;
		busDisable = 1'b0;
		resToDl    = 1'b0;
		res        = '0;
		dataOut    = 1'b0;
		dv         = '0;
		rd         = 1'b0;
		wr         = 1'b0;
		ieSelect   = 1'b0;
		extIn      = '0;
		resetDut();
		afterReset();
		aluOntoDl();
		readsOntoDl();
		writesOntoD();
		holdAndConflict();
		mixedBackToBack();
		repeat (FLUSH_CYCLES) applyCycle(idleStim()); // last results out
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dataMux.f ====
+incdir+source
source/busCyclePkg.sv
source/dataPathPkg.sv
source/dlBusIf.sv
source/busKeeper.sv
source/busSampler.sv
source/dlResolver.sv
source/busDriver.sv
source/dataMux.sv
verification/dataMuxTb.sv

// ==== Bender.yml ====
package:
  name: dataMux

sources:
  - include_dirs:
      - source
    files:
      - source/busCyclePkg.sv
      - source/dataPathPkg.sv
      - source/dlBusIf.sv
      - source/busKeeper.sv
      - source/busSampler.sv
      - source/dlResolver.sv
      - source/busDriver.sv
      - source/dataMux.sv

  - target: test
    include_dirs:
      - source
    files:
      - verification/dataMuxTb.sv
